//--- source/store_cfg_pkg.sv
// geometry is fixed at compile time and every tile must occupy one contiguous block of memory
`default_nettype none

package store_cfg_pkg;

    // ========================================================================
    // tile geometry
    // ========================================================================

    // words per tile along depth, rows and columns
    localparam int TILE_M = 4;
    localparam int TILE_R = 4;
    localparam int TILE_C = 4;

    // tiles per output dimension
    localparam int TILES_M = 4;
    localparam int TILES_R = 4;
    localparam int TILES_C = 4;

    localparam int TILE_WORDS = TILE_M * TILE_R * TILE_C;

    // ========================================================================
    // word, beat and burst sizes
    // ========================================================================

    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = WORD_W / 8;
    localparam int TILE_BYTES     = TILE_WORDS * BYTES_PER_WORD;
    localparam int WORDS_PER_BEAT = 4;
    localparam int BEAT_W         = WORD_W * WORDS_PER_BEAT;

    // max words handed to the write master per go
    localparam int BLEN = 8;

    localparam int WCOUNT_W   = 12;
    localparam int BLEN_W     = 16;
    localparam int TILE_IDX_W = 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BEAT_W-1:0]     beat_t;
    typedef logic [WCOUNT_W-1:0]   wcount_t;
    typedef logic [BLEN_W-1:0]     blen_t;
    typedef logic [TILE_IDX_W-1:0] tile_idx_t;

endpackage

`default_nettype wire

//--- source/store_bus_pkg.sv
// register map assumes 32-bit APB data and byte offsets in an 8-bit address space
`default_nettype none

package store_bus_pkg;

    localparam int PADDR_W = 8;
    localparam int PDATA_W = 32;
    localparam int XADDR_W = 32;

    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [PDATA_W-1:0] pdata_t;
    typedef logic [XADDR_W-1:0] xaddr_t;

    // ========================================================================
    // register offsets
    // ========================================================================

    localparam paddr_t REG_OUT_BASE = 8'h00;
    localparam paddr_t REG_TILE     = 8'h04;
    localparam paddr_t REG_CTRL     = 8'h08;
    localparam paddr_t REG_STATUS   = 8'h0C;

    // output base is word aligned
    localparam pdata_t OUT_BASE_MASK = 32'hFFFF_FFFC;

    // field positions in REG_TILE
    localparam int TILE_COL_LSB   = 0;
    localparam int TILE_ROW_LSB   = 8;
    localparam int TILE_DEPTH_LSB = 16;

    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

//--- source/store_reg_decode.sv
// zero wait state APB slave and only one store may be in flight at a time
`timescale 1ns/100ps
`default_nettype none

module store_reg_decode (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire store_bus_pkg::paddr_t   paddr,
    input  wire store_bus_pkg::pdata_t   pwdata,
    output store_bus_pkg::pdata_t        prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire logic                    finished,
    output logic                         start,
    output store_bus_pkg::xaddr_t        base,
    output store_cfg_pkg::wcount_t       length
);
    import store_cfg_pkg::*;
    import store_bus_pkg::*;

    xaddr_t    out_base;
    tile_idx_t tile_col;
    tile_idx_t tile_row;
    tile_idx_t tile_depth;
    logic      busy;
    logic      done_flag;

    logic      access;
    logic      addr_ok;
    logic      tile_ok;
    logic      start_req;
    logic      start_ok;
    logic      err;
    xaddr_t    tile_index;
    xaddr_t    tile_addr;

    // ========================================================================
    // APB access decode
    // ========================================================================

    assign access = psel && penable;
    assign pready = 1'b1;

    assign addr_ok = (paddr == REG_OUT_BASE) || (paddr == REG_TILE) ||
                     (paddr == REG_CTRL) || (paddr == REG_STATUS);

    // every coordinate must fall inside the output grid
    assign tile_ok = (pwdata[TILE_COL_LSB +: TILE_IDX_W] < TILES_C) &&
                     (pwdata[TILE_ROW_LSB +: TILE_IDX_W] < TILES_R) &&
                     (pwdata[TILE_DEPTH_LSB +: TILE_IDX_W] < TILES_M);

    assign start_req = access && pwrite && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];

    assign err = access && (!addr_ok ||
                            (pwrite && (paddr == REG_TILE) && !tile_ok) ||
                            (start_req && busy) ||
                            (pwrite && (paddr == REG_STATUS)));

    assign pslverr  = err;
    assign start_ok = start_req && !busy;

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_OUT_BASE: prdata = pdata_t'(out_base);
            REG_TILE: begin
                prdata[TILE_COL_LSB +: TILE_IDX_W]   = tile_col;
                prdata[TILE_ROW_LSB +: TILE_IDX_W]   = tile_row;
                prdata[TILE_DEPTH_LSB +: TILE_IDX_W] = tile_depth;
            end
            REG_STATUS: begin
                prdata[STATUS_BUSY_BIT] = busy;
                prdata[STATUS_DONE_BIT] = done_flag;
            end
            default: prdata = '0;
        endcase
    end

    // configuration registers, rejected writes leave them alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_base   <= '0;
            tile_col   <= '0;
            tile_row   <= '0;
            tile_depth <= '0;
        end else if (access && pwrite && !err) begin
            if (paddr == REG_OUT_BASE) begin
                out_base <= xaddr_t'(pwdata & OUT_BASE_MASK);
            end
            if (paddr == REG_TILE) begin
                tile_col   <= pwdata[TILE_COL_LSB +: TILE_IDX_W];
                tile_row   <= pwdata[TILE_ROW_LSB +: TILE_IDX_W];
                tile_depth <= pwdata[TILE_DEPTH_LSB +: TILE_IDX_W];
            end
        end
    end

    // ========================================================================
    // tile to address decode
    // ========================================================================

    // tiles are laid out depth major, then row, then column
    assign tile_index = (xaddr_t'(tile_depth) * xaddr_t'(TILES_R) + xaddr_t'(tile_row))
                        * xaddr_t'(TILES_C) + xaddr_t'(tile_col);
    assign tile_addr  = out_base + tile_index * xaddr_t'(TILE_BYTES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= start_ok;
            if (start_ok) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (finished) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            base   <= tile_addr;
            length <= wcount_t'(TILE_WORDS);
        end
    end

endmodule

`default_nettype wire

//--- source/word_packer.sv
// store FIFO must present a popped word on fifo_data in the cycle after its pop
`timescale 1ns/100ps
`default_nettype none

module word_packer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    start,
    input  wire store_cfg_pkg::wcount_t  length,
    input  wire store_cfg_pkg::word_t    fifo_data,
    input  wire logic                    fifo_empty,
    output logic                         fifo_pop,
    input  wire logic                    buffer_full,
    output store_cfg_pkg::beat_t         buffer_data,
    output logic                         buffer_write,
    output logic                         beat_written
);
    import store_cfg_pkg::*;

    logic                      active;
    wcount_t                   len_q;
    wcount_t                   pop_cnt;
    logic [WORDS_PER_BEAT-1:0] lane;
    logic [WORDS_PER_BEAT-1:0] lane_d1;
    logic [WORDS_PER_BEAT-1:0] lane_d2;
    word_t                     data_d1;
    beat_t                     beat_sr;
    logic                      write_pending;

    // pop only while words remain and both sides have room
    assign fifo_pop = active && !fifo_empty && !buffer_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            pop_cnt <= '0;
            lane    <= '0;
        end else if (start) begin
            active  <= (length != '0);
            pop_cnt <= '0;
            lane    <= WORDS_PER_BEAT'(1);
        end else if (fifo_pop) begin
            pop_cnt <= pop_cnt + wcount_t'(1);
            lane    <= {lane[WORDS_PER_BEAT-2:0], lane[WORDS_PER_BEAT-1]};
            if (pop_cnt + wcount_t'(1) == len_q) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            len_q <= length;
        end
    end

    // ========================================================================
    // lane pipeline and beat assembly
    // ========================================================================

    // lane tag follows the word, which reaches data_d1 two cycles after its pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_d1 <= '0;
            lane_d2 <= '0;
        end else begin
            lane_d1 <= fifo_pop ? lane : '0;
            lane_d2 <= lane_d1;
        end
    end

    always_ff @(posedge clk) begin
        data_d1 <= fifo_data;
        if (|lane_d2) begin
            beat_sr <= {data_d1, beat_sr[BEAT_W-1:WORD_W]};
        end
        // completed beat is parked so later words cannot disturb it
        if (lane_d2[WORDS_PER_BEAT-1]) begin
            buffer_data <= {data_d1, beat_sr[BEAT_W-1:WORD_W]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_pending <= 1'b0;
        end else if (lane_d2[WORDS_PER_BEAT-1]) begin
            write_pending <= 1'b1;
        end else if (buffer_write) begin
            write_pending <= 1'b0;
        end
    end

    // held back while the master buffer is full
    assign buffer_write = write_pending && !buffer_full;
    assign beat_written = buffer_write;

endmodule

`default_nettype wire

//--- source/burst_issuer.sv
// write master must drop done the cycle after go and raise it exactly once per burst
`timescale 1ns/100ps
`default_nettype none

module burst_issuer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    start,
    input  wire store_bus_pkg::xaddr_t   base,
    input  wire store_cfg_pkg::wcount_t  length,
    input  wire logic                    beat_written,
    input  wire logic                    done,
    output logic                         go,
    output store_bus_pkg::xaddr_t        write_base,
    output store_cfg_pkg::blen_t         write_length,
    output logic                         finished
);
    import store_cfg_pkg::*;
    import store_bus_pkg::*;

    logic    active;
    wcount_t len_q;
    wcount_t recv_cnt;
    wcount_t issued_cnt;
    wcount_t sent_cnt;
    wcount_t last_words;
    logic    go_q;
    logic    done_q;
    logic    done_rise;
    wcount_t remaining;
    wcount_t unsent;
    wcount_t burst_words;
    logic    full_burst;
    logic    tail_burst;

    // ========================================================================
    // burst sizing
    // ========================================================================

    assign remaining   = len_q - issued_cnt;
    assign unsent      = recv_cnt - issued_cnt;
    assign burst_words = (remaining > wcount_t'(BLEN)) ? wcount_t'(BLEN) : remaining;

    assign write_length = blen_t'(burst_words) * blen_t'(BYTES_PER_WORD);

    assign full_burst = (unsent >= wcount_t'(BLEN));
    // last short burst waits until every word has been buffered
    assign tail_burst = (remaining != '0) && (remaining < wcount_t'(BLEN)) &&
                        (recv_cnt == len_q);

    assign go = active && done && !go_q && (full_burst || tail_burst);

    // one rising edge of done per finished burst
    assign done_rise = done && !done_q;

    assign finished = active && (sent_cnt == len_q) && done && !go_q;

    // ========================================================================
    // counters
    // ========================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            recv_cnt   <= '0;
            issued_cnt <= '0;
            sent_cnt   <= '0;
            last_words <= '0;
            go_q       <= 1'b0;
            done_q     <= 1'b1;
        end else begin
            go_q   <= go;
            done_q <= done;
            if (start) begin
                active     <= 1'b1;
                recv_cnt   <= '0;
                issued_cnt <= '0;
                sent_cnt   <= '0;
                last_words <= '0;
            end else begin
                if (beat_written) begin
                    recv_cnt <= recv_cnt + wcount_t'(WORDS_PER_BEAT);
                end
                if (go) begin
                    issued_cnt <= issued_cnt + burst_words;
                    last_words <= burst_words;
                end
                if (done_rise) begin
                    sent_cnt <= sent_cnt + last_words;
                end
                if (finished) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            len_q <= length;
        end
    end

    // base moves past each burst as it is issued
    always_ff @(posedge clk) begin
        if (start) begin
            write_base <= base;
        end else if (go) begin
            write_base <= write_base + xaddr_t'(write_length);
        end
    end

endmodule

`default_nettype wire

//--- source/tile_store_top.sv
// store FIFO, write master and memory sit outside and follow the handshakes of the stages
`timescale 1ns/100ps
`default_nettype none

module tile_store_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // APB
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire store_bus_pkg::paddr_t   paddr,
    input  wire store_bus_pkg::pdata_t   pwdata,
    output store_bus_pkg::pdata_t        prdata,
    output logic                         pready,
    output logic                         pslverr,
    // store FIFO
    input  wire store_cfg_pkg::word_t    fifo_data,
    input  wire logic                    fifo_empty,
    output logic                         fifo_pop,
    // write master
    input  wire logic                    buffer_full,
    output store_cfg_pkg::beat_t         buffer_data,
    output logic                         buffer_write,
    input  wire logic                    done,
    output logic                         go,
    output store_bus_pkg::xaddr_t        write_base,
    output store_cfg_pkg::blen_t         write_length
);
    import store_cfg_pkg::*;
    import store_bus_pkg::*;

    logic    start;
    xaddr_t  base;
    wcount_t length;
    logic    finished;
    logic    beat_written;

    store_reg_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .finished (finished),
        .start    (start),
        .base     (base),
        .length   (length)
    );

    word_packer i_packer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .length       (length),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .buffer_full  (buffer_full),
        .buffer_data  (buffer_data),
        .buffer_write (buffer_write),
        .beat_written (beat_written)
    );

    burst_issuer i_issuer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .base         (base),
        .length       (length),
        .beat_written (beat_written),
        .done         (done),
        .go           (go),
        .write_base   (write_base),
        .write_length (write_length),
        .finished     (finished)
    );

endmodule

`default_nettype wire

//--- verification/tile_store_props.sv
// handshakes are sampled on the rising edge with inputs settling after it, idle while in reset
`timescale 1ns/100ps
`default_nettype none

module tile_store_props (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 fifo_pop,
    input wire store_cfg_pkg::word_t fifo_data,
    input wire logic                 buffer_write,
    input wire logic                 go,
    input wire logic                 done,
    input wire store_cfg_pkg::blen_t write_length
);
    import store_cfg_pkg::*;

    // words in the master buffer not yet claimed by a burst
    int words_buffered;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            words_buffered <= 0;
        end else begin
            words_buffered <= words_buffered + (buffer_write ? WORDS_PER_BEAT : 0)
                              - (go ? int'(write_length) / BYTES_PER_WORD : 0);
        end
    end

    // ========================================================================
    // store FIFO and master buffer
    // ========================================================================

    fifo_word_held: assert property (@(posedge clk) disable iff (rst)
        !$past(fifo_pop) |-> $stable(fifo_data))
        else $error("fifo_data changed without a pop");

    burst_buffered: assert property (@(posedge clk) disable iff (rst)
        go |-> (words_buffered >= int'(write_length) / BYTES_PER_WORD))
        else $error("burst issued before its words reached the master buffer");

    // ========================================================================
    // burst commands
    // ========================================================================

    done_drops_after_go: assert property (@(posedge clk) disable iff (rst)
        go |=> !done)
        else $error("done stayed high in the cycle after go");

    done_falls_on_go: assert property (@(posedge clk) disable iff (rst)
        $fell(done) |-> $past(go))
        else $error("done fell without a preceding go");

endmodule

bind tile_store_top tile_store_props i_props (
    .clk          (clk),
    .rst          (rst),
    .fifo_pop     (fifo_pop),
    .fifo_data    (fifo_data),
    .buffer_write (buffer_write),
    .go           (go),
    .done         (done),
    .write_length (write_length)
);

`default_nettype wire

//--- verification/tb_tile_store.sv
// FIFO never runs dry for good and the master holds 16 beats; tiles of one run must not overlap
`timescale 1ns/100ps
`default_nettype none

module tb_tile_store;
    import store_cfg_pkg::*;
    import store_bus_pkg::*;

    localparam int NUM_STORES   = 5;
    localparam int MASTER_BEATS = 16;
    // five stores at eight stall cycles per word, plus room for register traffic
    localparam int TIMEOUT_CYCLES = NUM_STORES * TILE_WORDS * 8 + 1500;

    logic   clk;
    logic   rst;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    pdata_t pwdata;
    pdata_t prdata;
    logic   pready;
    logic   pslverr;
    word_t  fifo_data;
    logic   fifo_empty;
    logic   fifo_pop;
    logic   buffer_full;
    beat_t  buffer_data;
    logic   buffer_write;
    logic   done;
    logic   go;
    xaddr_t write_base;
    blen_t  write_length;

    integer seed;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     cycles = 0;

    // FIFO and write master model state
    word_t  popped[$];
    beat_t  beats[$];
    word_t  mem[xaddr_t];
    xaddr_t burst_addr;
    int     burst_left = 0;
    xaddr_t base_reg;
    xaddr_t tile_addr;
    int     issued_bytes = 0;
    int     exp_len;

    // outputs captured at the falling edge
    logic   s_pop = 1'b0;
    logic   s_write = 1'b0;
    logic   s_go = 1'b0;
    beat_t  s_data;
    xaddr_t s_base;
    blen_t  s_len;

    tile_store_top i_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run stopped: stores did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // ========================================================================
    // FIFO and write master models
    // ========================================================================

    always @(negedge clk) begin
        s_pop   = fifo_pop;
        s_write = buffer_write;
        s_data  = buffer_data;
        s_go    = go;
        s_base  = write_base;
        s_len   = write_length;
        if (!rst) begin
            assert (!(fifo_pop && fifo_empty)) else begin
                protocol_errors++;
                $display("pop requested while the store FIFO was empty, cycle %0d", cycles);
            end
            assert (!(buffer_write && buffer_full)) else begin
                protocol_errors++;
                $display("beat written while the master buffer was full, cycle %0d", cycles);
            end
            assert (!(go && !done)) else begin
                protocol_errors++;
                $display("burst issued while the write master was busy, cycle %0d", cycles);
            end
            if (go) begin
                exp_len = TILE_BYTES - issued_bytes;
                if (exp_len > BLEN * BYTES_PER_WORD) begin
                    exp_len = BLEN * BYTES_PER_WORD;
                end
                check_equal("write_base", write_base, tile_addr + xaddr_t'(issued_bytes));
                check_equal("write_length", 32'(write_length), exp_len);
                issued_bytes += write_length;
            end
        end
    end

    task automatic drain_beat();
        beat_t beat;
        int    k;
        beat = beats.pop_front();
        for (k = 0; k < WORDS_PER_BEAT; k++) begin
            mem[burst_addr >> 2] = beat[32*k +: 32];
            burst_addr += 4;
            burst_left--;
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (s_write) begin
            beats.push_back(s_data);
        end
        if (s_pop) begin
            fifo_data = $random(seed);
            popped.push_back(fifo_data);
        end
        // done drops the cycle after go and rises when the burst has drained
        if (s_go) begin
            burst_addr = s_base;
            burst_left = s_len / BYTES_PER_WORD;
            done       = 1'b0;
        end else if (burst_left > 0 && beats.size() > 0 && ($random(seed) & 1)) begin
            drain_beat();
            if (burst_left <= 0) begin
                done = 1'b1;
            end
        end
        fifo_empty  = (($random(seed) & 3) == 0);
        buffer_full = (beats.size() >= MASTER_BEATS) || (($random(seed) & 7) == 0);
    end

    // ========================================================================
    // APB access and store sequence
    // ========================================================================

    task automatic bus_access(input logic write, input paddr_t addr, input pdata_t data,
                              output pdata_t rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_equal("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input paddr_t addr, input pdata_t data, input logic exp_err);
        pdata_t rdata;
        logic   err;
        bus_access(1'b1, addr, data, rdata, err);
        check_equal("pslverr", 32'(err), 32'(exp_err));
    endtask

    task automatic read_reg(input paddr_t addr, output pdata_t rdata);
        logic err;
        bus_access(1'b0, addr, '0, rdata, err);
        check_equal("pslverr", 32'(err), 32'h0);
    endtask

    task automatic run_store(input int col, input int row, input int depth);
        pdata_t rdata;
        int     n;
        tile_addr    = base_reg + xaddr_t'(((depth * 4 + row) * 4 + col) * 256);
        issued_bytes = 0;
        popped.delete();
        write_reg(REG_TILE, pdata_t'((depth << 16) | (row << 8) | col), 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        read_reg(REG_STATUS, rdata);
        check_equal("status", rdata, 32'h1);
        // a second start must bounce while the first is running
        write_reg(REG_CTRL, 32'h1, 1'b1);
        rdata = '0;
        while (rdata[1] !== 1'b1) begin
            read_reg(REG_STATUS, rdata);
        end
        check_equal("status", rdata, 32'h2);
        check_equal("write_length sum", issued_bytes, 256);
        check_equal("popped words", popped.size(), 64);
        for (n = 0; n < 64; n++) begin
            check_equal($sformatf("mem[%h]", tile_addr + 4 * n),
                        mem[(tile_addr + xaddr_t'(4 * n)) >> 2], popped[n]);
        end
    endtask

    initial begin
        pdata_t      rdata;
        pdata_t      base_val;
        pdata_t      tile_val;
        logic        err;
        logic [63:0] used;
        int          col;
        int          row;
        int          depth;
        int          idx;
        int          s;
        seed        = 32'h8459_df10;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        fifo_data   = '0;
        fifo_empty  = 1'b1;
        buffer_full = 1'b0;
        done        = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // register readback
        read_reg(REG_STATUS, rdata);
        check_equal("status", rdata, 32'h0);
        base_val = $random(seed);
        base_reg = base_val & 32'hFFFF_FFFC;
        write_reg(REG_OUT_BASE, base_val, 1'b0);
        read_reg(REG_OUT_BASE, rdata);
        check_equal("out_base", rdata, base_reg);
        tile_val = $random(seed) & 32'h0003_0303;
        write_reg(REG_TILE, tile_val, 1'b0);
        read_reg(REG_TILE, rdata);
        check_equal("tile", rdata, tile_val);

        // rejected accesses leave every register alone
        write_reg(8'h10, 32'hFFFF_FFFF, 1'b1);
        bus_access(1'b0, 8'h20, '0, rdata, err);
        check_equal("pslverr", 32'(err), 32'h1);
        write_reg(REG_TILE, tile_val | 32'h0000_0004, 1'b1);
        write_reg(REG_TILE, tile_val | 32'h0004_0000, 1'b1);
        write_reg(REG_STATUS, 32'h3, 1'b1);
        read_reg(REG_OUT_BASE, rdata);
        check_equal("out_base", rdata, base_reg);
        read_reg(REG_TILE, rdata);
        check_equal("tile", rdata, tile_val);
        read_reg(REG_STATUS, rdata);
        check_equal("status", rdata, 32'h0);

        // stores to distinct random tiles
        used = '0;
        for (s = 0; s < NUM_STORES; s++) begin
            do begin
                col   = $random(seed) & 3;
                row   = $random(seed) & 3;
                depth = $random(seed) & 3;
                idx   = (depth * 4 + row) * 4 + col;
            end while (used[idx]);
            used[idx] = 1'b1;
            run_store(col, row, depth);
        end

        $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/store_cfg_pkg.sv
source/store_bus_pkg.sv
source/store_reg_decode.sv
source/word_packer.sv
source/burst_issuer.sv
source/tile_store_top.sv
verification/tile_store_props.sv
verification/tb_tile_store.sv

//--- Bender.yml
package:
  name: tile_store

sources:
  # packages
  - source/store_cfg_pkg.sv
  - source/store_bus_pkg.sv
  # RTL
  - source/store_reg_decode.sv
  - source/word_packer.sv
  - source/burst_issuer.sv
  - source/tile_store_top.sv
  # verification
  - target: test
    files:
      - verification/tile_store_props.sv
      - verification/tb_tile_store.sv
